/* bench/mic1_tb.sv */
`timescale 1ns/100ps

`include "mic1_settings.svh"

module mic1_tb;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 16;
    localparam int PROG_WORDS     = 4;
    localparam int NUM_ROWS       = 12;
    localparam int CYCLES_PER_ROW = 400;
    localparam int HOLD_CYCLES    = 20;

    logic               clk;
    logic               resetn;
    logic               load_en;
    logic [`MEM_AW-1:0] load_addr;
    logic [`WORD_W-1:0] load_data;
    logic [`WORD_W-1:0] tos;
    logic               halted;

    // Program bytes in execution order, leftmost byte sits at address 0
    logic [127:0]       row_prog [NUM_ROWS];
    logic [`WORD_W-1:0] row_tos  [NUM_ROWS];

    mic1_top dut_i (
        .clk       (clk),
        .resetn    (resetn),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .tos       (tos),
        .halted    (halted)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fill_table();
        // BIPUSH 0x85, HALT
        row_prog[0]  = 128'h1085ffff_ffffffff_ffffffff_ffffffff;
        row_tos[0]   = 32'hffff_ff85;
        // 7 3 ISUB
        row_prog[1]  = 128'h10071003_64ffffff_ffffffff_ffffffff;
        row_tos[1]   = 32'h0000_0004;
        // 7 3 IADD
        row_prog[2]  = 128'h10071003_60ffffff_ffffffff_ffffffff;
        row_tos[2]   = 32'h0000_000a;
        // 12 DUP IAND
        row_prog[3]  = 128'h100c597e_ffffffff_ffffffff_ffffffff;
        row_tos[3]   = 32'h0000_000c;
        // 5 9 POP
        row_prog[4]  = 128'h10051009_57ffffff_ffffffff_ffffffff;
        row_tos[4]   = 32'h0000_0005;
        // 3 4 IOR
        row_prog[5]  = 128'h10031004_80ffffff_ffffffff_ffffffff;
        row_tos[5]   = 32'h0000_0007;
        // 9 NOP NOP -16 ISUB, so 9 minus -16
        row_prog[6]  = 128'h10090000_10f064ff_ffffffff_ffffffff;
        row_tos[6]   = 32'h0000_0019;
        // Forward GOTO skips BIPUSH 2
        row_prog[7]  = 128'h1001a700_051002ff_ffffffff_ffffffff;
        row_tos[7]   = 32'h0000_0001;
        // GOTO +6, BIPUSH 5, GOTO -5 back to BIPUSH 7
        row_prog[8]  = 128'ha7000610_07ff1005_a7fffbff_ffffffff;
        row_tos[8]   = 32'h0000_0007;
        // IFEQ on zero is taken and lands on HALT
        row_prog[9]  = 128'h102a1000_99000510_02ffffff_ffffffff;
        row_tos[9]   = 32'h0000_002a;
        // IFEQ on 5 falls through to BIPUSH 2
        row_prog[10] = 128'h102a1005_99000510_02ffffff_ffffffff;
        row_tos[10]  = 32'h0000_0002;
        // Push chain mixed with IADDs, 0x11 + 0x22 + 0x33 + 0x44 + 0x55
        row_prog[11] = 128'h10111022_10331044_60606010_5560ffff;
        row_tos[11]  = 32'h0000_00ff;
    endtask

    // Little-endian packing of four program bytes into one memory word
    function automatic logic [`WORD_W-1:0] program_word(input logic [127:0] prog, input int w);
        logic [`WORD_W-1:0] word;
        word = '0;
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = prog[127 - 8*(4*w + i) -: 8];
        end
        return word;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    // Program words go in during the first reset cycles
    task automatic reset_and_load(input int row);
        @(negedge clk);
        resetn = 1'b0;
        for (int cyc = 0; cyc < RESET_CYCLES; cyc++) begin
            if (cyc < PROG_WORDS) begin
                load_en   = 1'b1;
                load_addr = `MEM_AW'(cyc);
                load_data = program_word(row_prog[row], cyc);
            end else begin
                load_en = 1'b0;
            end
            @(negedge clk);
        end
        load_en = 1'b0;
        assert (!halted) else report_failure("halted was high while the core was in reset");
    endtask

    task automatic run_program(input int row);
        resetn = 1'b1;
        @(negedge clk);
        assert (!halted)
            else report_failure($sformatf("Row %0d raised halted right after reset", row));
        while (!halted) begin
            @(negedge clk);
        end
    endtask

    task automatic check_result(input int row);
        logic [`WORD_W-1:0] held;
        assert (tos === row_tos[row])
            else report_failure($sformatf("Mismatch in row %0d: tos is %h, expected %h",
                                          row, tos, row_tos[row]));
        held = tos;
        // Core spins on HALT, the stack top must stay put
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            assert (tos === held)
                else report_failure($sformatf("Mismatch in row %0d: tos is %h after halt, was %h",
                                              row, tos, held));
            assert (halted)
                else report_failure($sformatf("Row %0d dropped halted after reaching HALT", row));
        end
    endtask

    initial begin
        clk       = 1'b0;
        resetn    = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        fill_table();
        for (int row = 0; row < NUM_ROWS; row++) begin
            reset_and_load(row);
            run_program(row);
            check_result(row);
        end
        $display("TEST OK");
        $finish;
    end

    // Budget of 400 cycles per row
    initial begin
        #(NUM_ROWS * CYCLES_PER_ROW * CLK_PERIOD);
        report_failure("Timeout: the programs did not all reach HALT in the cycle budget");
    end

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module mic1_tb -f verilog.f -o mic1_sim \
    && ./obj_dir/mic1_sim | tee /dev/stderr | grep -q "TEST OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* source/main_memory.sv */
`timescale 1ns/100ps

`include "mic1_settings.svh"

module main_memory (
    input  logic               clk,
    input  logic               mem_en,
    input  logic               mem_we,
    input  logic [`MEM_AW-1:0] mem_addr,
    input  logic [`WORD_W-1:0] mem_wdata,
    output logic [`WORD_W-1:0] mem_rdata,
    input  logic               load_en,
    input  logic [`MEM_AW-1:0] load_addr,
    input  logic [`WORD_W-1:0] load_data
);

    logic [`WORD_W-1:0] ram [`MEM_WORDS];

    // Program loading wins over core writes
    always_ff @(posedge clk) begin
        if (load_en) begin
            ram[load_addr] <= load_data;
        end else if (mem_en && mem_we) begin
            ram[mem_addr] <= mem_wdata;
        end
    end

    // Registered read, one cycle after mem_en
    always_ff @(posedge clk) begin
        if (mem_en) begin
            mem_rdata <= ram[mem_addr];
        end
    end

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/100ps

`include "mic1_settings.svh"

module mem_arbiter (
    input  logic               clk,
    input  logic               resetn,

    input  logic               data_req,
    input  logic               data_we,
    input  logic [`MEM_AW-1:0] data_addr,
    input  logic [`WORD_W-1:0] data_wdata,
    output logic               data_ack,
    output logic [`WORD_W-1:0] data_rdata,

    input  logic               fetch_req,
    input  logic [`WORD_W-1:0] fetch_addr,
    output logic               fetch_ack,
    output logic [7:0]         fetch_byte,

    output logic               mem_en,
    output logic               mem_we,
    output logic [`MEM_AW-1:0] mem_addr,
    output logic [`WORD_W-1:0] mem_wdata,
    input  logic [`WORD_W-1:0] mem_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_HOLD
    } arb_state_t;

    arb_state_t         state;
    logic               last_fetch;
    logic               gnt_fetch;
    logic               pick_fetch;
    logic [`WORD_W-1:0] rdata_q;

    // Alternate when both wait, otherwise serve whoever asks
    assign pick_fetch = fetch_req && (!data_req || !last_fetch);

    // The access is issued straight out of idle
    assign mem_en    = (state == ST_IDLE) && (data_req || fetch_req);
    assign mem_we    = !pick_fetch && data_we;
    assign mem_addr  = pick_fetch ? fetch_addr[`MEM_AW+1:2] : data_addr;
    assign mem_wdata = data_wdata;

    assign data_rdata = rdata_q;

    // Little-endian byte lanes
    always_comb begin
        case (fetch_addr[1:0])
            2'd0:    fetch_byte = rdata_q[7:0];
            2'd1:    fetch_byte = rdata_q[15:8];
            2'd2:    fetch_byte = rdata_q[23:16];
            default: fetch_byte = rdata_q[31:24];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= ST_IDLE;
            last_fetch <= 1'b1;
            gnt_fetch  <= 1'b0;
            data_ack   <= 1'b0;
            fetch_ack  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (mem_en) begin
                        gnt_fetch  <= pick_fetch;
                        last_fetch <= pick_fetch;
                        state      <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    rdata_q   <= mem_rdata;
                    data_ack  <= !gnt_fetch;
                    fetch_ack <= gnt_fetch;
                    state     <= ST_HOLD;
                end
                default: begin
                    if (gnt_fetch ? !fetch_req : !data_req) begin
                        data_ack  <= 1'b0;
                        fetch_ack <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* source/mic1_alu.sv */
`timescale 1ns/100ps

`include "mic1_settings.svh"

module mic1_alu import mic1_pkg::*; (
    input  logic [5:0]         alu_ctrl,
    input  logic [1:0]         shift_ctrl,
    input  logic [`WORD_W-1:0] a,
    input  logic [`WORD_W-1:0] b,
    output logic [`WORD_W-1:0] c,
    output logic               n,
    output logic               z
);

    logic [`WORD_W-1:0] a_in;
    logic [`WORD_W-1:0] b_in;
    logic [`WORD_W-1:0] result;

    // ENA, ENB and INVA shape the operands
    always_comb begin
        a_in = alu_ctrl[3] ? a : '0;
        if (alu_ctrl[1]) begin
            a_in = ~a_in;
        end
        b_in = alu_ctrl[2] ? b : '0;
    end

    always_comb begin
        case (alu_fn_t'(alu_ctrl[5:4]))
            a_and_b:  result = a_in & b_in;
            a_or_b:   result = a_in | b_in;
            not_b:    result = ~b_in;
            default:  result = a_in + b_in + {{(`WORD_W-1){1'b0}}, alu_ctrl[0]};
        endcase
    end

    // Flags come from the unshifted result
    assign n = result[`WORD_W-1];
    assign z = (result == '0);

    always_comb begin
        case (shift_ctrl)
            SHIFT_SLL8: c = result << 8;
            SHIFT_SRA1: c = $signed(result) >>> 1;
            default:    c = result;
        endcase
    end

endmodule

/* source/mic1_control_store.sv */
`timescale 1ns/100ps

`include "mic1_settings.svh"

module mic1_control_store import mic1_pkg::*; (
    input  logic [`UADDR_W-1:0] upc,
    output micro_instr_t        mir
);

    localparam logic [8:0] CM_NONE = 9'b0;

    function automatic micro_instr_t uop(
        input logic [8:0] next_addr,
        input logic [2:0] jump,
        input logic [1:0] shift,
        input logic [5:0] alu,
        input logic [8:0] c_mask,
        input logic [2:0] mem,
        input b_sel_t     b_sel
    );
        micro_instr_t w;
        w.next_addr = next_addr;
        w.jump      = jump_ctrl_t'(jump);
        w.shift     = shift;
        w.alu       = alu;
        w.c_mask    = c_mask;
        w.mem       = mem_ctrl_t'(mem);
        w.b_sel     = b_sel;
        return w;
    endfunction

    function automatic logic [8:0] cm(input c_bit_e bit_a, input c_bit_e bit_b);
        logic [8:0] m;
        m = '0;
        m[bit_a] = 1'b1;
        m[bit_b] = 1'b1;
        return m;
    endfunction

    // Mem field is write/read/fetch, jump field is jmpc/jamn/jamz
    always_comb begin
        case (upc)
            // Main1, PC ends up on the opcode it dispatches
            9'h000: mir = uop(9'h000, 3'b100, SHIFT_NONE, ALU_B_PLUS_1, cm(C_PC, C_PC), 3'b001, pc);
            // BIPUSH
            9'h010: mir = uop(9'h020, 3'b000, SHIFT_NONE, ALU_B_PLUS_1, cm(C_SP, C_MAR), 3'b000, sp);
            9'h020: mir = uop(9'h021, 3'b000, SHIFT_NONE, ALU_B_PLUS_1, cm(C_PC, C_PC), 3'b001, pc);
            9'h021: mir = uop(9'h000, 3'b000, SHIFT_NONE, ALU_B, cm(C_MDR, C_TOS), 3'b100, mbr);
            // POP
            9'h057: mir = uop(9'h02b, 3'b000, SHIFT_NONE, ALU_B_MINUS_1, cm(C_SP, C_MAR), 3'b010, sp);
            9'h02b: mir = uop(9'h000, 3'b000, SHIFT_NONE, ALU_B, cm(C_TOS, C_TOS), 3'b000, mdr);
            // DUP
            9'h059: mir = uop(9'h02a, 3'b000, SHIFT_NONE, ALU_B_PLUS_1, cm(C_SP, C_MAR), 3'b000, sp);
            9'h02a: mir = uop(9'h000, 3'b000, SHIFT_NONE, ALU_B, cm(C_MDR, C_MDR), 3'b100, tos);
            // IADD
            9'h060: mir = uop(9'h022, 3'b000, SHIFT_NONE, ALU_B_MINUS_1, cm(C_SP, C_MAR), 3'b010, sp);
            9'h022: mir = uop(9'h023, 3'b000, SHIFT_NONE, ALU_B, cm(C_H, C_H), 3'b000, tos);
            9'h023: mir = uop(9'h000, 3'b000, SHIFT_NONE, ALU_A_PLUS_B, cm(C_MDR, C_TOS), 3'b100, mdr);
            // ISUB, second operand minus top
            9'h064: mir = uop(9'h024, 3'b000, SHIFT_NONE, ALU_B_MINUS_1, cm(C_SP, C_MAR), 3'b010, sp);
            9'h024: mir = uop(9'h025, 3'b000, SHIFT_NONE, ALU_B, cm(C_H, C_H), 3'b000, tos);
            9'h025: mir = uop(9'h000, 3'b000, SHIFT_NONE, ALU_B_MINUS_A, cm(C_MDR, C_TOS), 3'b100, mdr);
            // IAND
            9'h07e: mir = uop(9'h026, 3'b000, SHIFT_NONE, ALU_B_MINUS_1, cm(C_SP, C_MAR), 3'b010, sp);
            9'h026: mir = uop(9'h027, 3'b000, SHIFT_NONE, ALU_B, cm(C_H, C_H), 3'b000, tos);
            9'h027: mir = uop(9'h000, 3'b000, SHIFT_NONE, ALU_A_AND_B, cm(C_MDR, C_TOS), 3'b100, mdr);
            // IOR
            9'h080: mir = uop(9'h028, 3'b000, SHIFT_NONE, ALU_B_MINUS_1, cm(C_SP, C_MAR), 3'b010, sp);
            9'h028: mir = uop(9'h029, 3'b000, SHIFT_NONE, ALU_B, cm(C_H, C_H), 3'b000, tos);
            9'h029: mir = uop(9'h000, 3'b000, SHIFT_NONE, ALU_A_OR_B, cm(C_MDR, C_TOS), 3'b100, mdr);
            // IFEQ pops into TOS, tests the old top in OPC
            9'h099: mir = uop(9'h032, 3'b000, SHIFT_NONE, ALU_B_MINUS_1, cm(C_SP, C_MAR), 3'b010, sp);
            9'h032: mir = uop(9'h033, 3'b000, SHIFT_NONE, ALU_B, cm(C_OPC, C_OPC), 3'b000, tos);
            9'h033: mir = uop(9'h034, 3'b000, SHIFT_NONE, ALU_B, cm(C_TOS, C_TOS), 3'b000, mdr);
            9'h034: mir = uop(9'h035, 3'b001, SHIFT_NONE, ALU_B, CM_NONE, 3'b000, opc);
            // Not taken, step over the two offset bytes
            9'h035: mir = uop(9'h036, 3'b000, SHIFT_NONE, ALU_B_PLUS_1, cm(C_PC, C_PC), 3'b000, pc);
            9'h036: mir = uop(9'h000, 3'b000, SHIFT_NONE, ALU_B_PLUS_1, cm(C_PC, C_PC), 3'b000, pc);
            // Taken joins the GOTO path
            9'h135: mir = uop(9'h02c, 3'b000, SHIFT_NONE, ALU_B_MINUS_1, cm(C_OPC, C_OPC), 3'b000, pc);
            // GOTO, OPC is one below the opcode so Main1 lands on the target
            9'h0a7: mir = uop(9'h02c, 3'b000, SHIFT_NONE, ALU_B_MINUS_1, cm(C_OPC, C_OPC), 3'b000, pc);
            9'h02c: mir = uop(9'h02d, 3'b000, SHIFT_NONE, ALU_B_PLUS_1, cm(C_PC, C_PC), 3'b001, pc);
            9'h02d: mir = uop(9'h02e, 3'b000, SHIFT_SLL8, ALU_B, cm(C_H, C_H), 3'b000, mbr);
            9'h02e: mir = uop(9'h02f, 3'b000, SHIFT_NONE, ALU_B_PLUS_1, cm(C_PC, C_PC), 3'b001, pc);
            9'h02f: mir = uop(9'h030, 3'b000, SHIFT_NONE, ALU_A_OR_B, cm(C_H, C_H), 3'b000, mbru);
            9'h030: mir = uop(9'h000, 3'b000, SHIFT_NONE, ALU_A_PLUS_B, cm(C_PC, C_PC), 3'b000, opc);
            // HALT spins in place
            `HALT_UADDR: mir = uop(`HALT_UADDR, 3'b000, SHIFT_NONE, ALU_B, CM_NONE, 3'b000, tos);
            default: mir = uop(9'h000, 3'b000, SHIFT_NONE, ALU_B, CM_NONE, 3'b000, tos);
        endcase
    end

endmodule

/* source/mic1_core.sv */
`timescale 1ns/100ps

`include "mic1_settings.svh"

module mic1_core import mic1_pkg::*; (
    input  logic                clk,
    input  logic                resetn,

    output logic [`UADDR_W-1:0] upc,
    input  micro_instr_t        mir,

    output logic                data_req,
    output logic                data_we,
    output logic [`MEM_AW-1:0]  data_addr,
    output logic [`WORD_W-1:0]  data_wdata,
    input  logic                data_ack,
    input  logic [`WORD_W-1:0]  data_rdata,

    output logic                fetch_req,
    output logic [`WORD_W-1:0]  fetch_addr,
    input  logic                fetch_ack,
    input  logic [7:0]          fetch_byte,

    output logic [`WORD_W-1:0]  tos,
    output logic                halted
);

    logic [`WORD_W-1:0] mar_q, mdr_q, pc_q, sp_q, lv_q, cpp_q, opc_q, h_q;
    logic [7:0]         mbr_q;
    logic [`WORD_W-1:0] b_bus;
    logic [`WORD_W-1:0] c_bus;
    logic               alu_n, alu_z;
    logic               n_q, z_q;
    logic               busy;
    logic               flag_n, flag_z;
    logic               jam;
    logic               ports_done;
    logic [`UADDR_W-1:0] next_upc;

    mic1_alu alu_i (
        .alu_ctrl   (mir.alu),
        .shift_ctrl (mir.shift),
        .a          (h_q),
        .b          (b_bus),
        .c          (c_bus),
        .n          (alu_n),
        .z          (alu_z)
    );

    // The tos port hides the imported B select value of the same name
    always_comb begin
        case (mir.b_sel)
            mdr:           b_bus = mdr_q;
            pc:            b_bus = pc_q;
            mbr:           b_bus = {{(`WORD_W-8){mbr_q[7]}}, mbr_q};
            mbru:          b_bus = {{(`WORD_W-8){1'b0}}, mbr_q};
            sp:            b_bus = sp_q;
            lv:            b_bus = lv_q;
            cpp:           b_bus = cpp_q;
            mic1_pkg::tos: b_bus = tos;
            opc:           b_bus = opc_q;
            default:       b_bus = '0;
        endcase
    end

    // Flags captured at issue stand in for the stale live ones after a stall
    assign flag_n = busy ? n_q : alu_n;
    assign flag_z = busy ? z_q : alu_z;
    assign jam    = (mir.jump.jamn & flag_n) | (mir.jump.jamz & flag_z);

    always_comb begin
        if (mir.jump.jmpc) begin
            next_upc = mir.next_addr | {1'b0, mbr_q};
        end else begin
            next_upc = {mir.next_addr[8] | jam, mir.next_addr[7:0]};
        end
    end

    // A port is finished once both req and ack are low again
    assign ports_done = !data_req && !data_ack && !fetch_req && !fetch_ack;

    assign data_addr  = mar_q[`MEM_AW-1:0];
    assign data_wdata = mdr_q;
    assign fetch_addr = pc_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mar_q     <= '0;
            mdr_q     <= '0;
            pc_q      <= '1;
            sp_q      <= `WORD_W'(`STACK_BASE);
            lv_q      <= '0;
            cpp_q     <= '0;
            tos       <= '0;
            opc_q     <= '0;
            h_q       <= '0;
            mbr_q     <= '0;
            n_q       <= 1'b0;
            z_q       <= 1'b0;
            busy      <= 1'b0;
            data_req  <= 1'b0;
            data_we   <= 1'b0;
            fetch_req <= 1'b0;
            upc       <= '0;
            halted    <= 1'b0;
        end else begin
            if (!busy) begin
                if (mir.c_mask[C_MAR]) mar_q <= c_bus;
                if (mir.c_mask[C_MDR]) mdr_q <= c_bus;
                if (mir.c_mask[C_PC])  pc_q  <= c_bus;
                if (mir.c_mask[C_SP])  sp_q  <= c_bus;
                if (mir.c_mask[C_LV])  lv_q  <= c_bus;
                if (mir.c_mask[C_CPP]) cpp_q <= c_bus;
                if (mir.c_mask[C_TOS]) tos   <= c_bus;
                if (mir.c_mask[C_OPC]) opc_q <= c_bus;
                if (mir.c_mask[C_H])   h_q   <= c_bus;
                n_q <= alu_n;
                z_q <= alu_z;
                if (|mir.mem) begin
                    // Requests go out the cycle after MAR and PC settle
                    busy      <= 1'b1;
                    data_req  <= mir.mem.read | mir.mem.write;
                    data_we   <= mir.mem.write;
                    fetch_req <= mir.mem.fetch;
                end else begin
                    upc <= next_upc;
                end
            end else begin
                if (data_req && data_ack) begin
                    data_req <= 1'b0;
                    if (!data_we) begin
                        mdr_q <= data_rdata;
                    end
                end
                if (fetch_req && fetch_ack) begin
                    fetch_req <= 1'b0;
                    mbr_q     <= fetch_byte;
                end
                if (ports_done) begin
                    busy <= 1'b0;
                    upc  <= next_upc;
                end
            end
            if (upc == `HALT_UADDR) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

/* source/mic1_pkg.sv */
package mic1_pkg;

`include "mic1_settings.svh"

    // B bus sources
    typedef enum logic [3:0] {
        mdr  = 4'd0,
        pc   = 4'd1,
        mbr  = 4'd2,
        mbru = 4'd3,
        sp   = 4'd4,
        lv   = 4'd5,
        cpp  = 4'd6,
        tos  = 4'd7,
        opc  = 4'd8
    } b_sel_t;

    // Bit positions within the C write mask
    typedef enum int {
        C_MAR = 0,
        C_MDR = 1,
        C_PC  = 2,
        C_SP  = 3,
        C_LV  = 4,
        C_CPP = 5,
        C_TOS = 6,
        C_OPC = 7,
        C_H   = 8
    } c_bit_e;

    typedef struct packed {
        logic write;
        logic read;
        logic fetch;
    } mem_ctrl_t;

    typedef struct packed {
        logic jmpc;
        logic jamn;
        logic jamz;
    } jump_ctrl_t;

    typedef struct packed {
        logic [`UADDR_W-1:0] next_addr;
        jump_ctrl_t          jump;
        logic [1:0]          shift;
        logic [5:0]          alu;
        logic [8:0]          c_mask;
        mem_ctrl_t           mem;
        b_sel_t              b_sel;
    } micro_instr_t;

    // F0 F1 function select
    typedef enum logic [1:0] {
        a_and_b  = 2'b00,
        a_or_b   = 2'b01,
        not_b    = 2'b10,
        a_plus_b = 2'b11
    } alu_fn_t;

    // ALU control words, F0 F1 ENA ENB INVA INC
    localparam logic [5:0] ALU_B         = 6'b010100;
    localparam logic [5:0] ALU_B_PLUS_1  = 6'b110101;
    localparam logic [5:0] ALU_B_MINUS_1 = 6'b110110;
    localparam logic [5:0] ALU_A_PLUS_B  = 6'b111100;
    localparam logic [5:0] ALU_B_MINUS_A = 6'b111111;
    localparam logic [5:0] ALU_A_AND_B   = 6'b001100;
    localparam logic [5:0] ALU_A_OR_B    = 6'b011100;

    // Shifter control
    localparam logic [1:0] SHIFT_NONE = 2'b00;
    localparam logic [1:0] SHIFT_SRA1 = 2'b01;
    localparam logic [1:0] SHIFT_SLL8 = 2'b10;

endpackage

/* source/mic1_settings.svh */
`ifndef MIC1_SETTINGS_SVH
`define MIC1_SETTINGS_SVH

// Microinstruction and sequencer widths
`define MIR_W 36
`define UADDR_W 9

// Datapath width
`define WORD_W 32

// Main memory geometry, in 32-bit words
`define MEM_WORDS 256
`define MEM_AW 8

// SP after reset, as a word address
`define STACK_BASE 64

// Opcode 8'hff lands here and spins
`define HALT_UADDR 9'h0ff

`endif

/* source/mic1_top.sv */
`timescale 1ns/100ps

`include "mic1_settings.svh"

module mic1_top import mic1_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  logic               load_en,
    input  logic [`MEM_AW-1:0] load_addr,
    input  logic [`WORD_W-1:0] load_data,
    output logic [`WORD_W-1:0] tos,
    output logic               halted
);

    logic [`UADDR_W-1:0] upc;
    micro_instr_t        mir;

    logic                data_req, data_we, data_ack;
    logic [`MEM_AW-1:0]  data_addr;
    logic [`WORD_W-1:0]  data_wdata, data_rdata;

    logic                fetch_req, fetch_ack;
    logic [`WORD_W-1:0]  fetch_addr;
    logic [7:0]          fetch_byte;

    logic                mem_en, mem_we;
    logic [`MEM_AW-1:0]  mem_addr;
    logic [`WORD_W-1:0]  mem_wdata, mem_rdata;

    mic1_core core_i (
        .clk        (clk),
        .resetn     (resetn),
        .upc        (upc),
        .mir        (mir),
        .data_req   (data_req),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_ack   (data_ack),
        .data_rdata (data_rdata),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ack  (fetch_ack),
        .fetch_byte (fetch_byte),
        .tos        (tos),
        .halted     (halted)
    );

    mic1_control_store cstore_i (
        .upc (upc),
        .mir (mir)
    );

    mem_arbiter arb_i (
        .clk        (clk),
        .resetn     (resetn),
        .data_req   (data_req),
        .data_we    (data_we),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_ack   (data_ack),
        .data_rdata (data_rdata),
        .fetch_req  (fetch_req),
        .fetch_addr (fetch_addr),
        .fetch_ack  (fetch_ack),
        .fetch_byte (fetch_byte),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

    main_memory mem_i (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

/* verilog.f */
+incdir+source
source/mic1_pkg.sv
source/mic1_alu.sv
source/mic1_control_store.sv
source/mic1_core.sv
source/mem_arbiter.sv
source/main_memory.sv
source/mic1_top.sv
bench/mic1_tb.sv
